// ==== include/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// fetch address width and block size
`define ICACHE_ADDR_BITS 64
`define ICACHE_BLOCK_BITS 64

// address split: tag | index | offset
`define ICACHE_OFFSET_BITS 3
`define ICACHE_INDEX_BITS 5
`define ICACHE_TAG_BITS 56

// one line per index, direct mapped
`define ICACHE_LINES 32

// one table entry per memory transaction tag
`define ICACHE_TAGTAB_SIZE 16

// max prefetches in flight
`define ICACHE_PREF_DEPTH 8

`endif

// ==== src/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

	// command driven on the memory bus
	// the cache only ever issues loads
	typedef enum logic [1:0] {
		BUS_NONE = 2'd0,
		BUS_LOAD = 2'd1
	} bus_command_t;

	// transaction tag handed out by memory
	typedef logic [3:0] mem_tag_t;

	// response value for a stall, tag value for an idle cycle
	localparam mem_tag_t NO_TAG = 4'd0;

endpackage

`default_nettype wire

// ==== src/icache_pkg.sv ====
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

	// fields of a fetch address
	typedef logic [`ICACHE_INDEX_BITS-1:0] line_index_t;
	typedef logic [`ICACHE_TAG_BITS-1:0] line_tag_t;
	typedef logic [`ICACHE_OFFSET_BITS-1:0] line_offset_t;

	// tag in the upper bits, byte offset in the lower bits
	typedef struct packed {
		line_tag_t tag;
		line_index_t index;
		line_offset_t offset;
	} fetch_fields_t;

	// same word seen as a plain address or as its cache fields
	typedef union packed {
		logic [`ICACHE_ADDR_BITS-1:0] raw;
		fetch_fields_t fields;
	} fetch_addr_t;

endpackage

`default_nettype wire

// ==== src/icache_prefetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_prefetch (
	input wire clock,
	input wire reset,
	input wire branch_mispredict,
	input wire logic [`ICACHE_ADDR_BITS-1:0] pc_target,
	input wire pref_issued,
	input wire pref_done,
	output icache_pkg::fetch_addr_t pref_addr,
	output logic pref_request
);

	localparam int COUNT_BITS = $clog2(`ICACHE_PREF_DEPTH + 1);

	// distance between two consecutive blocks
	localparam logic [`ICACHE_ADDR_BITS-1:0] BLOCK_STEP = {
		{(`ICACHE_ADDR_BITS - `ICACHE_OFFSET_BITS - 1){1'b0}},
		1'b1,
		{`ICACHE_OFFSET_BITS{1'b0}}
	};

	logic [COUNT_BITS-1:0] pending_count;
	logic active;

	// idle until the first branch target is known
	assign pref_request = active && (pending_count < `ICACHE_PREF_DEPTH);

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			pref_addr <= '0;
		end else if (branch_mispredict) begin
			// restart at the block of the new target
			active <= 1'b1;
			pref_addr.raw <= {
				pc_target[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
				{`ICACHE_OFFSET_BITS{1'b0}}
			};
		end else if (pref_issued) begin
			pref_addr.raw <= pref_addr.raw + BLOCK_STEP;
		end
	end

	// fills still arrive after a mispredict, so the count is never cleared by it.
	// a prefetch that hits raises issued and done together and leaves the count alone
	always_ff @(posedge clock) begin
		if (reset) begin
			pending_count <= '0;
		end else begin
			case ({pref_issued, pref_done})
				2'b10: pending_count <= pending_count + 1'b1;
				2'b01: pending_count <= pending_count - 1'b1;
				default: pending_count <= pending_count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/icache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_controller (
	input wire clock,
	input wire reset,
	input wire icache_pkg::fetch_addr_t proc2icache_addr,
	input wire mem_bus_pkg::bus_command_t proc2icache_command,
	input wire icache_pkg::fetch_addr_t pref_addr,
	input wire pref_request,
	input wire mem_bus_pkg::mem_tag_t mem2proc_response,
	input wire mem_bus_pkg::mem_tag_t mem2proc_tag,
	input wire logic [`ICACHE_BLOCK_BITS-1:0] mem2proc_data,
	input wire demand_hit,
	input wire pref_hit,
	input wire logic [`ICACHE_BLOCK_BITS-1:0] demand_data,
	output mem_bus_pkg::bus_command_t proc2mem_command,
	output logic [`ICACHE_ADDR_BITS-1:0] proc2mem_addr,
	output icache_pkg::line_index_t demand_index,
	output icache_pkg::line_index_t pref_index,
	output icache_pkg::line_tag_t demand_tag,
	output icache_pkg::line_tag_t pref_tag,
	output logic fill_enable,
	output icache_pkg::line_index_t fill_index,
	output icache_pkg::line_tag_t fill_tag,
	output logic [`ICACHE_BLOCK_BITS-1:0] fill_data,
	output logic [`ICACHE_BLOCK_BITS-1:0] data_out,
	output logic data_valid,
	output logic pref_issued,
	output logic pref_done
);

	// outstanding loads, entry number is the memory tag
	logic [`ICACHE_TAGTAB_SIZE-1:0] tab_valid;
	logic [`ICACHE_TAGTAB_SIZE-1:0] tab_pref;
	icache_pkg::line_index_t tab_index [`ICACHE_TAGTAB_SIZE];
	icache_pkg::line_tag_t tab_tag [`ICACHE_TAGTAB_SIZE];

	icache_pkg::fetch_addr_t demand_block;
	icache_pkg::fetch_addr_t pref_block;
	logic demand_load;
	logic demand_pending;
	logic pref_pending;
	logic demand_miss;
	logic pref_miss;
	logic pref_skip;
	logic fill_is_pref;
	logic issue_pref;
	logic accepted;

	assign demand_index = proc2icache_addr.fields.index;
	assign demand_tag = proc2icache_addr.fields.tag;
	assign pref_index = pref_addr.fields.index;
	assign pref_tag = pref_addr.fields.tag;

	assign demand_load = (proc2icache_command == mem_bus_pkg::BUS_LOAD);
	assign data_out = demand_data;
	assign data_valid = demand_load && demand_hit;

	// is the block already on its way from memory
	always_comb begin
		demand_pending = 1'b0;
		pref_pending = 1'b0;
		for (int i = 0; i < `ICACHE_TAGTAB_SIZE; i++) begin
			if (tab_valid[i] && tab_index[i] == demand_index && tab_tag[i] == demand_tag)
				demand_pending = 1'b1;
			if (tab_valid[i] && tab_index[i] == pref_index && tab_tag[i] == pref_tag)
				pref_pending = 1'b1;
		end
	end

	assign demand_miss = demand_load && !demand_hit && !demand_pending;
	assign pref_miss = pref_request && !pref_hit && !pref_pending;

	// returning data, steered to the line recorded with its tag
	assign fill_enable = (mem2proc_tag != mem_bus_pkg::NO_TAG) && tab_valid[mem2proc_tag];
	assign fill_is_pref = fill_enable && tab_pref[mem2proc_tag];
	assign fill_index = tab_index[mem2proc_tag];
	assign fill_tag = tab_tag[mem2proc_tag];
	assign fill_data = mem2proc_data;

	// a prefetch hit skips the bus, held off one cycle when a prefetch fill returns
	assign pref_skip = pref_request && pref_hit && !fill_is_pref;

	// demand miss first, prefetch miss otherwise
	always_comb begin
		demand_block = proc2icache_addr;
		demand_block.fields.offset = '0;
		pref_block = pref_addr;
		pref_block.fields.offset = '0;
		proc2mem_command = mem_bus_pkg::BUS_NONE;
		proc2mem_addr = demand_block.raw;
		issue_pref = 1'b0;
		if (demand_miss) begin
			proc2mem_command = mem_bus_pkg::BUS_LOAD;
		end else if (pref_miss) begin
			proc2mem_command = mem_bus_pkg::BUS_LOAD;
			proc2mem_addr = pref_block.raw;
			issue_pref = 1'b1;
		end
	end

	assign accepted = (proc2mem_command == mem_bus_pkg::BUS_LOAD) &&
		(mem2proc_response != mem_bus_pkg::NO_TAG);

	assign pref_issued = (accepted && issue_pref) || pref_skip;
	assign pref_done = fill_is_pref || pref_skip;

	// a tag freed and handed out again in one cycle stays valid
	always_ff @(posedge clock) begin
		if (reset) begin
			tab_valid <= '0;
		end else begin
			if (fill_enable)
				tab_valid[mem2proc_tag] <= 1'b0;
			if (accepted)
				tab_valid[mem2proc_response] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (accepted) begin
			tab_pref[mem2proc_response] <= issue_pref;
			tab_index[mem2proc_response] <= issue_pref ? pref_index : demand_index;
			tab_tag[mem2proc_response] <= issue_pref ? pref_tag : demand_tag;
		end
	end

endmodule

`default_nettype wire

// ==== src/icache_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_mem (
	input wire clock,
	input wire reset,
	input wire icache_pkg::line_index_t demand_index,
	input wire icache_pkg::line_tag_t demand_tag,
	input wire icache_pkg::line_index_t pref_index,
	input wire icache_pkg::line_tag_t pref_tag,
	input wire fill_enable,
	input wire icache_pkg::line_index_t fill_index,
	input wire icache_pkg::line_tag_t fill_tag,
	input wire logic [`ICACHE_BLOCK_BITS-1:0] fill_data,
	output logic demand_hit,
	output logic pref_hit,
	output logic [`ICACHE_BLOCK_BITS-1:0] demand_data
);

	logic [`ICACHE_LINES-1:0] line_valid;
	icache_pkg::line_tag_t line_tag [`ICACHE_LINES];
	logic [`ICACHE_BLOCK_BITS-1:0] line_data [`ICACHE_LINES];

	// line present and holding the wanted block
	function automatic logic line_match(
		input icache_pkg::line_index_t index,
		input icache_pkg::line_tag_t tag
	);
		return line_valid[index] && (line_tag[index] == tag);
	endfunction

	// both ports read combinationally
	assign demand_hit = line_match(demand_index, demand_tag);
	assign pref_hit = line_match(pref_index, pref_tag);
	assign demand_data = line_data[demand_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else if (fill_enable) begin
			line_valid[fill_index] <= 1'b1;
		end
	end

	// fill replaces whatever block was at the index
	always_ff @(posedge clock) begin
		if (fill_enable) begin
			line_tag[fill_index] <= fill_tag;
			line_data[fill_index] <= fill_data;
		end
	end

endmodule

`default_nettype wire

// ==== src/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache (
	input wire clock,
	input wire reset,
	input wire icache_pkg::fetch_addr_t proc2icache_addr,
	input wire mem_bus_pkg::bus_command_t proc2icache_command,
	input wire branch_mispredict,
	input wire logic [`ICACHE_ADDR_BITS-1:0] pc_target,
	input wire mem_bus_pkg::mem_tag_t mem2proc_response,
	input wire mem_bus_pkg::mem_tag_t mem2proc_tag,
	input wire logic [`ICACHE_BLOCK_BITS-1:0] mem2proc_data,
	output mem_bus_pkg::bus_command_t proc2mem_command,
	output logic [`ICACHE_ADDR_BITS-1:0] proc2mem_addr,
	output logic [`ICACHE_BLOCK_BITS-1:0] icache2proc_data,
	output logic icache2proc_valid
);

	icache_pkg::fetch_addr_t pref_addr;
	logic pref_request;
	logic pref_issued;
	logic pref_done;
	icache_pkg::line_index_t demand_index;
	icache_pkg::line_index_t pref_index;
	icache_pkg::line_index_t fill_index;
	icache_pkg::line_tag_t demand_tag;
	icache_pkg::line_tag_t pref_tag;
	icache_pkg::line_tag_t fill_tag;
	logic fill_enable;
	logic [`ICACHE_BLOCK_BITS-1:0] fill_data;
	logic [`ICACHE_BLOCK_BITS-1:0] demand_data;
	logic demand_hit;
	logic pref_hit;
	logic data_valid;

	// the fetch in a mispredict cycle is on the wrong path
	assign icache2proc_valid = data_valid && !branch_mispredict;

	icache_prefetch u_prefetch (
		.clock(clock),
		.reset(reset),
		.branch_mispredict(branch_mispredict),
		.pc_target(pc_target),
		.pref_issued(pref_issued),
		.pref_done(pref_done),
		.pref_addr(pref_addr),
		.pref_request(pref_request)
	);

	icache_controller u_controller (
		.clock(clock),
		.reset(reset),
		.proc2icache_addr(proc2icache_addr),
		.proc2icache_command(proc2icache_command),
		.pref_addr(pref_addr),
		.pref_request(pref_request),
		.mem2proc_response(mem2proc_response),
		.mem2proc_tag(mem2proc_tag),
		.mem2proc_data(mem2proc_data),
		.demand_hit(demand_hit),
		.pref_hit(pref_hit),
		.demand_data(demand_data),
		.proc2mem_command(proc2mem_command),
		.proc2mem_addr(proc2mem_addr),
		.demand_index(demand_index),
		.pref_index(pref_index),
		.demand_tag(demand_tag),
		.pref_tag(pref_tag),
		.fill_enable(fill_enable),
		.fill_index(fill_index),
		.fill_tag(fill_tag),
		.fill_data(fill_data),
		.data_out(icache2proc_data),
		.data_valid(data_valid),
		.pref_issued(pref_issued),
		.pref_done(pref_done)
	);

	icache_mem u_mem (
		.clock(clock),
		.reset(reset),
		.demand_index(demand_index),
		.demand_tag(demand_tag),
		.pref_index(pref_index),
		.pref_tag(pref_tag),
		.fill_enable(fill_enable),
		.fill_index(fill_index),
		.fill_tag(fill_tag),
		.fill_data(fill_data),
		.demand_hit(demand_hit),
		.pref_hit(pref_hit),
		.demand_data(demand_data)
	);

endmodule

`default_nettype wire

// ==== test/icache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_checker (
	input wire clock,
	input wire reset,
	input wire logic [63:0] proc2icache_addr,
	input wire mem_bus_pkg::bus_command_t proc2icache_command,
	input wire branch_mispredict,
	input wire logic [63:0] pc_target,
	input wire mem_bus_pkg::mem_tag_t mem2proc_response,
	input wire mem_bus_pkg::mem_tag_t mem2proc_tag,
	input wire mem_bus_pkg::bus_command_t proc2mem_command,
	input wire logic [63:0] proc2mem_addr,
	input wire logic [63:0] icache2proc_data,
	input wire icache2proc_valid
);

	localparam logic [63:0] DATA_KEY = 64'h5a5a_0f0f_a5a5_f0f0;
	localparam int DEMAND_BOUND = 40;

	int checks [1:6];
	int errors [1:6];
	int total_errors;

	// reference copy of the lines and of the loads in flight
	logic m_valid [32];
	logic [63:0] m_block [32];
	logic o_busy [16];
	logic o_demand [16];
	logic [63:0] o_addr [16];

	int after_reset;
	int wait_cycles;
	logic [63:0] wait_addr;
	logic [63:0] floor_addr;
	logic watching;
	logic [63:0] blk;
	logic demand;
	logic accepted;
	int pref_out;

	function automatic string test_name(input int n);
		case (n)
			1: return "reset";
			2: return "data correctness";
			3: return "hit behavior";
			4: return "liveness";
			5: return "mispredict";
			default: return "bus discipline";
		endcase
	endfunction

	task automatic value_error(input int n, input string msg);
		$display("ERROR %0t: %s: %s", $time, test_name(n), msg);
		errors[n]++;
		total_errors++;
	endtask

	task automatic report();
		for (int n = 1; n <= 6; n++)
			$display("test %0d %s: %0d checks, %0d errors", n, test_name(n), checks[n], errors[n]);
		$display("summary: %0d tests, %0d errors", 6, total_errors);
	endtask

	initial begin
		total_errors = 0;
		for (int n = 1; n <= 6; n++) begin
			checks[n] = 0;
			errors[n] = 0;
		end
	end

	always @(negedge clock) begin
		blk = {proc2icache_addr[63:3], 3'b000};
		demand = (proc2icache_command == mem_bus_pkg::BUS_LOAD);
		accepted = (proc2mem_command == mem_bus_pkg::BUS_LOAD) && (mem2proc_response != 4'd0);
		if (reset) begin
			after_reset = 0;
			wait_cycles = 0;
			watching = 1'b0;
			for (int i = 0; i < 32; i++)
				m_valid[i] = 1'b0;
			for (int t = 0; t < 16; t++)
				o_busy[t] = 1'b0;
		end else begin
			// idle cycles first, then a fetch that cannot hit yet
			if (after_reset < 4) begin
				checks[1]++;
				if (!demand && proc2mem_command !== mem_bus_pkg::BUS_NONE)
					value_error(1, "bus command active with no fetch right after reset");
				if (icache2proc_valid !== 1'b0)
					value_error(1, "valid not low right after reset");
				after_reset++;
			end
			if (icache2proc_valid) begin
				checks[2]++;
				if (icache2proc_data !== (blk ^ DATA_KEY))
					value_error(2, $sformatf("data %h for address %h", icache2proc_data, blk));
			end
			if (demand && !branch_mispredict && m_valid[blk[7:3]] && m_block[blk[7:3]] == blk) begin
				checks[3]++;
				if (!icache2proc_valid)
					value_error(3, $sformatf("no valid for held block %h", blk));
				if (proc2mem_command == mem_bus_pkg::BUS_LOAD && proc2mem_addr == blk)
					value_error(3, $sformatf("load issued for held block %h", blk));
			end
			// cycles spent waiting on one demand
			if (!demand || branch_mispredict || icache2proc_valid) begin
				if (wait_cycles > 0)
					checks[4]++;
				wait_cycles = 0;
			end else if (proc2icache_addr !== wait_addr) begin
				wait_addr = proc2icache_addr;
				wait_cycles = 1;
			end else begin
				wait_cycles++;
				if (wait_cycles == DEMAND_BOUND)
					value_error(4, $sformatf("demand %h not served in time", wait_addr));
			end
			if (branch_mispredict) begin
				checks[5]++;
				if (icache2proc_valid)
					value_error(5, "valid high during a mispredict");
				floor_addr = {pc_target[63:3], 3'b000};
				watching = 1'b1;
			end else if (!demand && accepted && watching) begin
				checks[5]++;
				if (proc2mem_addr[2:0] != 3'b000 || proc2mem_addr < floor_addr)
					value_error(5, $sformatf("prefetch %h below %h", proc2mem_addr, floor_addr));
				floor_addr = proc2mem_addr + 64'd8;
			end
			if (accepted) begin
				checks[6]++;
				for (int t = 1; t < 16; t++) begin
					if (o_busy[t] && o_addr[t] == proc2mem_addr && !(mem2proc_tag == 4'(t)))
						value_error(6, $sformatf("block %h outstanding twice", proc2mem_addr));
				end
			end
			if (!demand) begin
				pref_out = 0;
				for (int t = 1; t < 16; t++)
					if (o_busy[t] && !o_demand[t])
						pref_out++;
				if (pref_out > `ICACHE_PREF_DEPTH)
					value_error(6, $sformatf("%0d prefetches outstanding", pref_out));
			end
			// the coming edge writes the fill and records the new load
			if (mem2proc_tag != 4'd0) begin
				m_valid[o_addr[mem2proc_tag][7:3]] = 1'b1;
				m_block[o_addr[mem2proc_tag][7:3]] = o_addr[mem2proc_tag];
				o_busy[mem2proc_tag] = 1'b0;
			end
			if (accepted) begin
				o_busy[mem2proc_response] = 1'b1;
				o_addr[mem2proc_response] = proc2mem_addr;
				o_demand[mem2proc_response] = demand && (proc2mem_addr == blk);
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module tb_icache;

	localparam int STIM_CYCLES = 2000;
	localparam int CYCLE_LIMIT = 20 * STIM_CYCLES;
	localparam logic [63:0] DATA_KEY = 64'h5a5a_0f0f_a5a5_f0f0;
	localparam logic [63:0] WINDOW_BASE = 64'h0000_0000_0000_1000;

	logic clock;
	logic reset;
	logic [63:0] proc2icache_addr;
	mem_bus_pkg::bus_command_t proc2icache_command;
	logic branch_mispredict;
	logic [63:0] pc_target;
	mem_bus_pkg::mem_tag_t mem2proc_response;
	mem_bus_pkg::mem_tag_t mem2proc_tag;
	logic [63:0] mem2proc_data;
	mem_bus_pkg::bus_command_t proc2mem_command;
	logic [63:0] proc2mem_addr;
	logic [63:0] icache2proc_data;
	logic icache2proc_valid;

	// memory model state, one slot per tag
	logic busy [1:15];
	logic [63:0] slot_addr [1:15];
	int slot_due [1:15];
	int mem_cycle;
	logic stall;
	mem_bus_pkg::mem_tag_t offer_tag;
	int start;
	int slot;

	int cycle_count;
	logic holding;
	logic got_valid;
	int idle_run;
	int pick;

	icache i_dut (
		.clock(clock),
		.reset(reset),
		.proc2icache_addr(proc2icache_addr),
		.proc2icache_command(proc2icache_command),
		.branch_mispredict(branch_mispredict),
		.pc_target(pc_target),
		.mem2proc_response(mem2proc_response),
		.mem2proc_tag(mem2proc_tag),
		.mem2proc_data(mem2proc_data),
		.proc2mem_command(proc2mem_command),
		.proc2mem_addr(proc2mem_addr),
		.icache2proc_data(icache2proc_data),
		.icache2proc_valid(icache2proc_valid)
	);

	icache_checker i_checker (
		.clock(clock),
		.reset(reset),
		.proc2icache_addr(proc2icache_addr),
		.proc2icache_command(proc2icache_command),
		.branch_mispredict(branch_mispredict),
		.pc_target(pc_target),
		.mem2proc_response(mem2proc_response),
		.mem2proc_tag(mem2proc_tag),
		.proc2mem_command(proc2mem_command),
		.proc2mem_addr(proc2mem_addr),
		.icache2proc_data(icache2proc_data),
		.icache2proc_valid(icache2proc_valid)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	// memory accepts in the same cycle unless it stalls
	assign mem2proc_response = (proc2mem_command == mem_bus_pkg::BUS_LOAD && !stall) ?
		offer_tag : 4'd0;

	// pick a free tag to offer and at most one due return per cycle
	always @(posedge clock) begin
		#2;
		mem_cycle++;
		mem2proc_tag = 4'd0;
		mem2proc_data = '0;
		for (int t = 1; t <= 15; t++) begin
			if (busy[t] && slot_due[t] <= mem_cycle && mem2proc_tag == 4'd0) begin
				mem2proc_tag = 4'(t);
				mem2proc_data = {slot_addr[t][63:3], 3'b000} ^ DATA_KEY;
			end
		end
		stall = ($urandom % 4) == 0;
		offer_tag = 4'd0;
		start = int'($urandom % 15);
		for (int k = 0; k < 15; k++) begin
			slot = 1 + (start + k) % 15;
			if (!busy[slot] && offer_tag == 4'd0)
				offer_tag = 4'(slot);
		end
	end

	// requests and returns take effect on the coming edge
	always @(negedge clock) begin
		if (reset) begin
			for (int t = 1; t <= 15; t++)
				busy[t] = 1'b0;
		end else begin
			if (mem2proc_tag != 4'd0)
				busy[mem2proc_tag] = 1'b0;
			if (proc2mem_command == mem_bus_pkg::BUS_LOAD && mem2proc_response != 4'd0) begin
				busy[mem2proc_response] = 1'b1;
				slot_addr[mem2proc_response] = proc2mem_addr;
				slot_due[mem2proc_response] = mem_cycle + 2 + int'($urandom % 9);
			end
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("run stopped: cycle limit of %0d reached, the DUT seems hung", CYCLE_LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h1ef0));
		mem_cycle = 0;
		cycle_count = 0;
		stall = 1'b0;
		offer_tag = 4'd0;
		mem2proc_tag = 4'd0;
		mem2proc_data = '0;
		proc2icache_addr = '0;
		proc2icache_command = mem_bus_pkg::BUS_NONE;
		branch_mispredict = 1'b0;
		pc_target = '0;
		holding = 1'b0;
		idle_run = 4;
		reset = 1'b1;
		repeat (5) @(posedge clock);
		#2 reset = 1'b0;

		// two idle cycles, then a first fetch while every line is still invalid
		repeat (2) @(posedge clock);
		#2;
		proc2icache_addr = WINDOW_BASE;
		proc2icache_command = mem_bus_pkg::BUS_LOAD;
		holding = 1'b1;

		repeat (STIM_CYCLES) begin
			@(negedge clock);
			got_valid = icache2proc_valid;
			@(posedge clock);
			#2;
			branch_mispredict = 1'b0;
			if (holding && got_valid)
				holding = 1'b0;
			pick = int'($urandom % 25);
			if (pick == 0) begin
				// jump away and watch the prefetcher for a while
				// the fetch still on the port is on the wrong path
				branch_mispredict = 1'b1;
				pc_target = WINDOW_BASE + 64'($urandom % 1024);
				proc2icache_command = mem_bus_pkg::BUS_LOAD;
				holding = 1'b0;
				idle_run = 3 + int'($urandom % 8);
			end else if (holding) begin
				proc2icache_command = mem_bus_pkg::BUS_LOAD;
			end else if (idle_run > 0) begin
				idle_run--;
				proc2icache_command = mem_bus_pkg::BUS_NONE;
			end else if (pick < 5) begin
				proc2icache_command = mem_bus_pkg::BUS_NONE;
			end else begin
				proc2icache_addr = WINDOW_BASE + 64'($urandom % 1024);
				proc2icache_command = mem_bus_pkg::BUS_LOAD;
				holding = 1'b1;
			end
		end

		@(posedge clock);
		#2;
		branch_mispredict = 1'b0;
		proc2icache_command = mem_bus_pkg::BUS_NONE;
		repeat (20) @(posedge clock);
		i_checker.report();
		if (i_checker.total_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
src/mem_bus_pkg.sv
src/icache_pkg.sv
src/icache_prefetch.sv
src/icache_controller.sv
src/icache_mem.sv
src/icache.sv
test/icache_checker.sv
test/tb_icache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_icache -o tb_icache_sim \
	&& ./obj_dir/tb_icache_sim | tee /dev/stderr | grep -x "TB PASSED" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
